// ==== common/histPkg.sv ====
package histPkg;

    // default sizes, the top level passes these down as module parameters
    localparam int pixelNumDef = 4;
    localparam int binNumDef = 12;      // not a power of two, range check matters
    localparam int countWidthDef = 4;   // small so counts can saturate

    // builder phases for one acquisition
    typedef enum logic [2:0] {
        idle,           // waiting for acqStart
        clear,          // zeroing the histogram RAM
        accumulate,     // taking samples
        drain,          // letting in-flight increments finish
        search          // peak search running on port B
    } builderPhase;

endpackage

// ==== logic/sampleIngest.sv ====
module sampleIngest #(
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int binNum = histPkg::binNumDef
) (
    input  logic clk,
    input  logic res,
    input  logic accumulating,
    input  logic sampleValid,
    input  logic [$clog2(pixelNum):0] samplePixel,    // one spare bit for out-of-range values
    input  logic [$clog2(binNum):0] sampleBin,
    output logic hitValid,
    output logic [$clog2(pixelNum*binNum)-1:0] hitAddr,
    output logic [15:0] dropCount
);

    localparam int addrWidth = $clog2(pixelNum * binNum);

    logic inRange;
    logic accept;
    logic reject;
    logic [addrWidth-1:0] flatAddr;

    assign inRange = (samplePixel < pixelNum) && (sampleBin < binNum);

    // samples outside accumulate are simply ignored, not counted
    assign accept = sampleValid && accumulating && inRange;
    assign reject = sampleValid && accumulating && !inRange;

    // pixel-major layout, bins of one pixel are contiguous
    assign flatAddr = addrWidth'(samplePixel) * addrWidth'(binNum) + addrWidth'(sampleBin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hitValid <= 1'b0;
            dropCount <= '0;
        end else begin
            hitValid <= accept;
            if (reject) begin
                dropCount <= dropCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        hitAddr <= flatAddr;    // qualified by hitValid
    end

endmodule

// ==== histBuilder/histRam.sv ====
module histRam #(
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int binNum = histPkg::binNumDef,
    parameter int countWidth = histPkg::countWidthDef
) (
    input  logic clk,
    input  logic wrEn,
    input  logic [$clog2(pixelNum*binNum)-1:0] wrAddr,
    input  logic [countWidth-1:0] wrData,
    input  logic rdEnA,
    input  logic [$clog2(pixelNum*binNum)-1:0] rdAddrA,
    output logic [countWidth-1:0] rdDataA,
    input  logic rdEnB,
    input  logic [$clog2(pixelNum*binNum)-1:0] rdAddrB,
    output logic [countWidth-1:0] rdDataB
);

    localparam int depth = pixelNum * binNum;

    logic [countWidth-1:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read-before-write, same-cycle writes show up one cycle later
    always_ff @(posedge clk) begin
        if (rdEnA) begin
            rdDataA <= mem[rdAddrA];
        end
        if (rdEnB) begin
            rdDataB <= mem[rdAddrB];    // peak search port
        end
    end

endmodule

// ==== histBuilder/histBuilder.sv ====
module histBuilder #(
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int binNum = histPkg::binNumDef,
    parameter int countWidth = histPkg::countWidthDef
) (
    input  logic clk,
    input  logic res,
    input  logic acqStart,
    input  logic acqEnd,
    input  logic hitValid,
    input  logic [$clog2(pixelNum*binNum)-1:0] hitAddr,
    input  logic [countWidth-1:0] rdDataA,
    input  logic searchDone,
    output logic accumulating,
    output logic acqReady,
    output logic rdEnA,
    output logic [$clog2(pixelNum*binNum)-1:0] rdAddrA,
    output logic wrEn,
    output logic [$clog2(pixelNum*binNum)-1:0] wrAddr,
    output logic [countWidth-1:0] wrData,
    output logic searchStart
);

    import histPkg::*;

    localparam int depth = pixelNum * binNum;
    localparam int addrWidth = $clog2(depth);

    builderPhase phase;
    logic [addrWidth-1:0] clearAddr;
    logic [1:0] drainCnt;

    // s1 waits for RAM data, s2 is the write on the port now, s3 the write before it
    logic s1Valid;
    logic s2Valid;
    logic s3Valid;
    logic [addrWidth-1:0] s1Addr;
    logic [addrWidth-1:0] s2Addr;
    logic [addrWidth-1:0] s3Addr;
    logic [countWidth-1:0] s2Data;
    logic [countWidth-1:0] s3Data;
    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] nextCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= idle;
            clearAddr <= '0;
            drainCnt <= '0;
            searchStart <= 1'b0;
        end else begin
            searchStart <= 1'b0;
            case (phase)
                idle: begin
                    if (acqStart) begin
                        phase <= clear;
                        clearAddr <= '0;
                    end
                end
                clear: begin
                    if (clearAddr == addrWidth'(depth - 1)) begin
                        phase <= accumulate;
                    end else begin
                        clearAddr <= clearAddr + 1'b1;
                    end
                end
                accumulate: begin
                    if (acqEnd) begin
                        phase <= drain;
                        drainCnt <= '0;
                    end
                end
                drain: begin
                    // three cycles covers the last hit's read and write
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == 2'd2) begin
                        phase <= search;
                        searchStart <= 1'b1;
                    end
                end
                search: begin
                    if (searchDone) begin
                        phase <= idle;
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    assign accumulating = (phase == accumulate);
    assign acqReady = accumulating;

    // read issued on the hit cycle itself
    assign rdEnA = hitValid;
    assign rdAddrA = hitAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= hitValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= hitAddr;
        s2Addr <= s1Addr;
        s2Data <= nextCount;
        s3Addr <= s2Addr;
        s3Data <= s2Data;
    end

    // newest pending write wins, RAM data is stale for both
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCount = s2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Data;
        end else begin
            baseCount = rdDataA;
        end
    end

    assign nextCount = (&baseCount) ? baseCount : baseCount + 1'b1;  // hold at max

    // clear and increments never overlap
    assign wrEn = (phase == clear) || s2Valid;
    assign wrAddr = (phase == clear) ? clearAddr : s2Addr;
    assign wrData = (phase == clear) ? '0 : s2Data;

endmodule

// ==== peakSearch/peakSearch.sv ====
module peakSearch #(
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int binNum = histPkg::binNumDef,
    parameter int countWidth = histPkg::countWidthDef
) (
    input  logic clk,
    input  logic res,
    input  logic searchStart,
    input  logic [countWidth-1:0] rdDataB,
    output logic rdEnB,
    output logic [$clog2(pixelNum*binNum)-1:0] rdAddrB,
    output logic peakValid,
    output logic [$clog2(pixelNum)-1:0] peakPixel,
    output logic [$clog2(binNum)-1:0] peakBin,
    output logic [countWidth-1:0] peakCount,
    output logic searchDone
);

    localparam int addrWidth = $clog2(pixelNum * binNum);
    localparam int pixWidth = $clog2(pixelNum);
    localparam int binWidth = $clog2(binNum);

    logic scanning;
    logic [pixWidth-1:0] pixCnt;
    logic [binWidth-1:0] binCnt;
    logic [addrWidth-1:0] scanAddr;
    logic lastBin;

    // aligned with rdAddrB
    logic [pixWidth-1:0] rdPixel;
    logic [binWidth-1:0] rdBin;
    logic rdLast;

    // aligned with rdDataB
    logic dValid;
    logic dLast;
    logic [pixWidth-1:0] dPixel;
    logic [binWidth-1:0] dBin;

    logic [binWidth-1:0] bestBin;
    logic [countWidth-1:0] bestCount;
    logic takeNew;

    assign lastBin = (binCnt == binWidth'(binNum - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            pixCnt <= '0;
            binCnt <= '0;
            scanAddr <= '0;
        end else if (searchStart) begin
            scanning <= 1'b1;
            pixCnt <= '0;
            binCnt <= '0;
            scanAddr <= '0;
        end else if (scanning) begin
            scanAddr <= scanAddr + 1'b1;    // flat address just counts up
            if (lastBin) begin
                binCnt <= '0;
                pixCnt <= pixCnt + 1'b1;
                if (pixCnt == pixWidth'(pixelNum - 1)) begin
                    scanning <= 1'b0;
                end
            end else begin
                binCnt <= binCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdEnB <= 1'b0;
            dValid <= 1'b0;
            peakValid <= 1'b0;
            searchDone <= 1'b0;
        end else begin
            rdEnB <= scanning;
            dValid <= rdEnB;
            peakValid <= dValid && dLast;
            searchDone <= peakValid && (peakPixel == pixWidth'(pixelNum - 1));
        end
    end

    always_ff @(posedge clk) begin
        rdAddrB <= scanAddr;
        rdPixel <= pixCnt;
        rdBin <= binCnt;
        rdLast <= lastBin;
        dPixel <= rdPixel;
        dBin <= rdBin;
        dLast <= rdLast;
    end

    // bin 0 seeds the max, later bins need a strictly greater count
    assign takeNew = (dBin == '0) || (rdDataB > bestCount);

    always_ff @(posedge clk) begin
        if (dValid && takeNew) begin
            bestBin <= dBin;
            bestCount <= rdDataB;
        end
        if (dValid && dLast) begin
            peakPixel <= dPixel;
            peakBin <= takeNew ? dBin : bestBin;
            peakCount <= takeNew ? rdDataB : bestCount;
        end
    end

endmodule

// ==== logic/histPeakTop.sv ====
module histPeakTop #(
    parameter int pixelNum = histPkg::pixelNumDef,
    parameter int binNum = histPkg::binNumDef,
    parameter int countWidth = histPkg::countWidthDef
) (
    input  logic clk,
    input  logic res,
    input  logic acqStart,
    input  logic sampleValid,
    input  logic [$clog2(pixelNum):0] samplePixel,
    input  logic [$clog2(binNum):0] sampleBin,
    input  logic acqEnd,
    output logic acqReady,
    output logic [15:0] dropCount,
    output logic peakValid,
    output logic [$clog2(pixelNum)-1:0] peakPixel,
    output logic [$clog2(binNum)-1:0] peakBin,
    output logic [countWidth-1:0] peakCount,
    output logic searchDone
);

    localparam int addrWidth = $clog2(pixelNum * binNum);

    logic accumulating;
    logic hitValid;
    logic [addrWidth-1:0] hitAddr;
    logic rdEnA;
    logic [addrWidth-1:0] rdAddrA;
    logic [countWidth-1:0] rdDataA;
    logic rdEnB;
    logic [addrWidth-1:0] rdAddrB;
    logic [countWidth-1:0] rdDataB;
    logic wrEn;
    logic [addrWidth-1:0] wrAddr;
    logic [countWidth-1:0] wrData;
    logic searchStart;

    sampleIngest #(
        .pixelNum(pixelNum),
        .binNum(binNum)
    ) sampleIngest_inst (
        .clk(clk),
        .res(res),
        .accumulating(accumulating),
        .sampleValid(sampleValid),
        .samplePixel(samplePixel),
        .sampleBin(sampleBin),
        .hitValid(hitValid),
        .hitAddr(hitAddr),
        .dropCount(dropCount)
    );

    histBuilder #(
        .pixelNum(pixelNum),
        .binNum(binNum),
        .countWidth(countWidth)
    ) histBuilder_inst (
        .clk(clk),
        .res(res),
        .acqStart(acqStart),
        .acqEnd(acqEnd),
        .hitValid(hitValid),
        .hitAddr(hitAddr),
        .rdDataA(rdDataA),
        .searchDone(searchDone),
        .accumulating(accumulating),
        .acqReady(acqReady),
        .rdEnA(rdEnA),
        .rdAddrA(rdAddrA),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .searchStart(searchStart)
    );

    // port A for increments, port B for the peak search
    histRam #(
        .pixelNum(pixelNum),
        .binNum(binNum),
        .countWidth(countWidth)
    ) histRam_inst (
        .clk(clk),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdEnA(rdEnA),
        .rdAddrA(rdAddrA),
        .rdDataA(rdDataA),
        .rdEnB(rdEnB),
        .rdAddrB(rdAddrB),
        .rdDataB(rdDataB)
    );

    peakSearch #(
        .pixelNum(pixelNum),
        .binNum(binNum),
        .countWidth(countWidth)
    ) peakSearch_inst (
        .clk(clk),
        .res(res),
        .searchStart(searchStart),
        .rdDataB(rdDataB),
        .rdEnB(rdEnB),
        .rdAddrB(rdAddrB),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .searchDone(searchDone)
    );

endmodule

// ==== tb/histPeakTop_properties.sv ====
module histPeakProperties (
    input logic clk,
    input logic res,
    input histPkg::builderPhase phase,
    input logic peakValid,
    input logic searchDone,
    input logic wrEn,
    input logic acqReady,
    input logic acqEnd
);

    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    // peak strobes only come out of a running search
    peakInSearch: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> phase == search)
        else $error("peakValid high outside the search phase");

    doneOneCycle: assert property (@(posedge clk) disable iff (!res)
        searchDone |=> !searchDone)
        else $error("searchDone held for more than one cycle");

    noWriteInIdle: assert property (@(posedge clk) disable iff (!res)
        !(wrEn && phase == idle))
        else $error("RAM write while the builder is idle");

    // end of acquisition closes the sample window on the next cycle
    readyDropsAfterEnd: assert property (@(posedge clk) disable iff (!res)
        acqReady && acqEnd |=> !acqReady)
        else $error("acqReady still high the cycle after acqEnd");

endmodule

// phase lives inside the builder, the strobes on the top level
bind histPeakTop histPeakProperties histPeakProperties_inst (
    .clk(clk),
    .res(res),
    .phase(histBuilder_inst.phase),
    .peakValid(peakValid),
    .searchDone(searchDone),
    .wrEn(wrEn),
    .acqReady(acqReady),
    .acqEnd(acqEnd)
);

// ==== tb/histPeakTb.sv ====
module histPeakTb;

    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    localparam int pixelNum = pixelNumDef;
    localparam int binNum = binNumDef;
    localparam int countWidth = countWidthDef;
    localparam int countMax = (1 << countWidth) - 1;
    localparam int readyLimit = 4 * pixelNum * binNum;    // clear takes pixelNum*binNum cycles
    localparam int peakLimit = 4 * binNum + 40;
    localparam int doneLimit = 8;

    logic clk;
    logic res;
    logic acqStart;
    logic sampleValid;
    logic [$clog2(pixelNum):0] samplePixel;
    logic [$clog2(binNum):0] sampleBin;
    logic acqEnd;
    logic acqReady;
    logic [15:0] dropCount;
    logic peakValid;
    logic [$clog2(pixelNum)-1:0] peakPixel;
    logic [$clog2(binNum)-1:0] peakBin;
    logic [countWidth-1:0] peakCount;
    logic searchDone;

    // reference histogram
    int modelCount [0:pixelNum*binNum-1];
    int modelDrops;
    bit modelOpen;      // model takes samples between start and end

    // peaks as the DUT reported them
    int gotPixel [$];
    int gotBin [$];
    int gotCount [$];
    int cycleNum;
    int lastPeakCycle;
    int lastPeakPixel;
    int doneSeen;
    int doneChecked;

    int errorCount;
    int checkCount;
    bit timedOut;

    histPeakTop histPeakTop_inst (
        .clk(clk),
        .res(res),
        .acqStart(acqStart),
        .sampleValid(sampleValid),
        .samplePixel(samplePixel),
        .sampleBin(sampleBin),
        .acqEnd(acqEnd),
        .acqReady(acqReady),
        .dropCount(dropCount),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .searchDone(searchDone)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // outputs are captured mid-cycle, away from the driving edge
    always @(negedge clk) begin
        cycleNum++;
        if (peakValid) begin
            gotPixel.push_back(peakPixel);
            gotBin.push_back(peakBin);
            gotCount.push_back(peakCount);
            lastPeakCycle = cycleNum;
            lastPeakPixel = peakPixel;
        end
        if (searchDone) begin
            doneSeen++;
            checkCount++;
            assert (lastPeakCycle == cycleNum - 1 && lastPeakPixel == pixelNum - 1) else begin
                $display("mismatch at %0d ns: searchDone not on the cycle after the last peak",
                    $time);
                errorCount++;
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        acqStart <= 1'b0;
        acqEnd <= 1'b0;
        sampleValid <= 1'b0;
    endtask

    task automatic startAcq();
        int waited;
        nextCycle();
        acqStart <= 1'b1;
        nextCycle();
        for (int i = 0; i < pixelNum * binNum; i++) begin
            modelCount[i] = 0;
        end
        waited = 0;
        @(negedge clk);
        while (!acqReady && waited < readyLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!acqReady) begin
            $display("acqReady did not rise within %0d cycles of acqStart", readyLimit);
            timedOut = 1'b1;
        end else begin
            // one write per RAM address before samples are taken
            checkCount++;
            assert (waited == pixelNum * binNum) else begin
                $display("mismatch at %0d ns: acqReady rose after %0d clear cycles, expected %0d",
                    $time, waited, pixelNum * binNum);
                errorCount++;
            end
        end
        modelOpen = 1'b1;
    endtask

    task automatic applySample(input int p, input int b);
        nextCycle();
        sampleValid <= 1'b1;
        samplePixel <= p;
        sampleBin <= b;
        if (modelOpen) begin
            if (p < pixelNum && b < binNum) begin
                if (modelCount[p * binNum + b] < countMax) begin
                    modelCount[p * binNum + b]++;   // count holds at its maximum
                end
            end else begin
                modelDrops++;
            end
        end
    endtask

    task automatic endAcq();
        nextCycle();
        acqEnd <= 1'b1;
        modelOpen = 1'b0;   // later samples are lost
    endtask

    task automatic checkPeak(input int p, input int b, input int c);
        int waited;
        int modelBin;
        int modelBest;
        int gp;
        int gb;
        int gc;
        nextCycle();
        // strictly greater only, so the lowest bin keeps a tie
        modelBin = 0;
        modelBest = modelCount[p * binNum];
        for (int i = 1; i < binNum; i++) begin
            if (modelCount[p * binNum + i] > modelBest) begin
                modelBin = i;
                modelBest = modelCount[p * binNum + i];
            end
        end
        checkCount++;
        assert (modelBin == b && modelBest == c) else begin
            $display("mismatch at %0d ns: pixel %0d vector bin %0d count %0d, model %0d %0d",
                $time, p, b, c, modelBin, modelBest);
            errorCount++;
        end
        waited = 0;
        while (gotPixel.size() == 0 && waited < peakLimit) begin
            nextCycle();
            waited++;
        end
        if (gotPixel.size() == 0) begin
            $display("no peakValid for pixel %0d before timeout", p);
            timedOut = 1'b1;
        end else begin
            gp = gotPixel.pop_front();
            gb = gotBin.pop_front();
            gc = gotCount.pop_front();
            checkCount++;
            assert (gp == p && gb == b && gc == c) else begin
                $display("mismatch at %0d ns: expected pixel %0d bin %0d count %0d, got %0d %0d %0d",
                    $time, p, b, c, gp, gb, gc);
                errorCount++;
            end
        end
        if (!timedOut && p == pixelNum - 1) begin
            waited = 0;
            while (doneSeen == doneChecked && waited < doneLimit) begin
                nextCycle();
                waited++;
            end
            if (doneSeen == doneChecked) begin
                $display("no searchDone after pixel %0d before timeout", p);
                timedOut = 1'b1;
            end
            doneChecked = doneSeen;
        end
    endtask

    task automatic checkDrops(input int n);
        nextCycle();
        @(negedge clk);
        checkCount++;
        assert (modelDrops == n && dropCount == n) else begin
            $display("mismatch at %0d ns: drops expected %0d, model %0d, dropCount %0d",
                $time, n, modelDrops, dropCount);
            errorCount++;
        end
    endtask

    initial begin
        int fd;
        int n;
        int a;
        int b;
        int c;
        logic [127:0] cmd;
        logic [1023:0] rest;
        res = 1'b0;
        acqStart = 1'b0;
        acqEnd = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleBin = '0;
        modelOpen = 1'b0;
        modelDrops = 0;
        cycleNum = 0;
        lastPeakCycle = -10;
        lastPeakPixel = -1;
        doneSeen = 0;
        doneChecked = 0;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        repeat (8) @(posedge clk);
        res <= 1'b1;
        fd = $fopen("tb/histVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/histVectors.txt");
            errorCount++;
        end else begin
            n = $fscanf(fd, " %s", cmd);
            while (n == 1 && !timedOut) begin
                if (cmd == "#") begin
                    n = $fgets(rest, fd);   // comment line
                end else if (cmd == "start") begin
                    startAcq();
                end else if (cmd == "sample") begin
                    n = $fscanf(fd, " %d %d", a, b);
                    applySample(a, b);
                end else if (cmd == "idle") begin
                    n = $fscanf(fd, " %d", a);
                    repeat (a) nextCycle();
                end else if (cmd == "end") begin
                    endAcq();
                end else if (cmd == "expect") begin
                    n = $fscanf(fd, " %d %d %d", a, b, c);
                    checkPeak(a, b, c);
                end else if (cmd == "drops") begin
                    n = $fscanf(fd, " %d", a);
                    checkDrops(a);
                end else begin
                    $display("unknown vector command %0s", cmd);
                    errorCount++;
                end
                n = $fscanf(fd, " %s", cmd);
            end
            $fclose(fd);
        end
        repeat (4) nextCycle();
        checkCount++;
        assert (gotPixel.size() == 0) else begin
            $display("mismatch at %0d ns: %0d peakValid strobes not covered by any vector",
                $time, gotPixel.size());
            errorCount++;
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/histPkg.sv
logic/sampleIngest.sv
histBuilder/histRam.sv
histBuilder/histBuilder.sv
peakSearch/peakSearch.sv
logic/histPeakTop.sv
tb/histPeakTop_properties.sv
tb/histPeakTb.sv

// ==== tb/histVectors.txt ====
# start | sample pixel bin | idle cycles | end | expect pixel bin count | drops total
# tokens are whitespace separated, consecutive sample commands go out back to back
start
sample 0 7
sample 0 7
sample 0 7
sample 0 3
sample 0 3
sample 0 3
sample 1 9
sample 1 9
sample 1 9
sample 1 9
sample 2 5
sample 2 12
sample 4 5
idle 1
sample 2 5
sample 3 11
idle 2
end
sample 3 4
sample 3 4
expect 0 3 3
expect 1 9 4
expect 2 5 2
expect 3 11 1
drops 2
# second run, alternating pairs drive bins 1 and 2 into saturation
start
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1  sample 0 2
sample 0 1
sample 0 1
sample 1 4
sample 7 31
end
expect 0 1 15
expect 1 4 1
expect 2 0 0
expect 3 0 0
drops 3
